// File: design/attn_settings.svh
`ifndef ATTN_SETTINGS_SVH
`define ATTN_SETTINGS_SVH

//////////////////////////////
// data and tile sizes
//////////////////////////////

`define ATTN_DW     8                         // element width
`define ATTN_TILE   4                         // tile rows and cols, SA size
`define ATTN_DK     8                         // key depth, cols of q k v

// number of v column tiles walked in the p*v step
`define ATTN_NTILE  (`ATTN_DK / `ATTN_TILE)

//////////////////////////////
// scale constant
//////////////////////////////

`define ATTN_SCALE  3                         // 1/sqrt(dk) in fixed point

`endif

// File: design/attn_pkg.sv
`default_nettype none

`include "attn_settings.svh"

package attn_pkg;

    typedef logic [`ATTN_DW-1:0] data_t;      // one matrix element
    typedef logic [7:0]          dim_t;       // inner dim told to the SA
    typedef logic [1:0]          tile_idx_t;  // v column tile index

    typedef enum logic [1:0] {
        BLK_Q = 2'd0,
        BLK_K = 2'd1,
        BLK_V = 2'd2
    } blk_id_e;

    typedef enum logic [3:0] {
        SEQ_IDLE      = 4'd0,
        SEQ_LOAD      = 4'd1,                 // waiting on the loader
        SEQ_CLR_QK    = 4'd2,
        SEQ_QK        = 4'd3,                 // s = q * k^t
        SEQ_CLR_SCALE = 4'd4,
        SEQ_SCALE     = 4'd5,                 // p = s * diag(scale)
        SEQ_CLR_PV    = 4'd6,
        SEQ_PV        = 4'd7,                 // o tile = p * v tile
        SEQ_DONE      = 4'd8
    } seq_state_e;

    typedef enum logic [1:0] {
        LD_IDLE     = 2'd0,
        LD_REQ      = 2'd1,                   // request held until valid
        LD_WAIT_GAP = 2'd2                    // one low cycle between blocks
    } load_state_e;

endpackage

`default_nettype wire

// File: design/attn_tile_loader.sv
`default_nettype none

`include "attn_settings.svh"

module attn_tile_loader (
    input  logic                  I_CLK,
    input  logic                  I_ASYN_RSTN,
    input  logic                  i_ld_go,
    input  logic                  i_bram_rd_vld,
    input  attn_pkg::data_t       i_bram_rd_mat [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output logic                  o_rd_ena,
    output attn_pkg::blk_id_e     o_bram_blk_sel,
    output logic                  o_ld_done,
    output attn_pkg::data_t       o_mat_q       [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output attn_pkg::data_t       o_mat_k       [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output attn_pkg::data_t       o_mat_v       [0:`ATTN_TILE-1][0:`ATTN_DK-1]
);

    attn_pkg::load_state_e state;
    logic                  blk_hit;           // block arrives this cycle

    assign blk_hit = (state == attn_pkg::LD_REQ) && i_bram_rd_vld;

    //////////////////////////////
    // request FSM
    //////////////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state          <= attn_pkg::LD_IDLE;
            o_rd_ena       <= 1'b0;
            o_bram_blk_sel <= attn_pkg::BLK_Q;
            o_ld_done      <= 1'b0;
        end else begin
            o_ld_done <= 1'b0;
            case (state)
                attn_pkg::LD_IDLE: begin
                    if (i_ld_go) begin
                        state          <= attn_pkg::LD_REQ;
                        o_rd_ena       <= 1'b1;
                        o_bram_blk_sel <= attn_pkg::BLK_Q;  // always start with q
                    end
                end
                attn_pkg::LD_REQ: begin
                    if (i_bram_rd_vld) begin
                        o_rd_ena <= 1'b0;
                        if (o_bram_blk_sel == attn_pkg::BLK_V) begin
                            state     <= attn_pkg::LD_IDLE;
                            o_ld_done <= 1'b1;              // all three held now
                        end else begin
                            state <= attn_pkg::LD_WAIT_GAP;
                            if (o_bram_blk_sel == attn_pkg::BLK_Q) begin
                                o_bram_blk_sel <= attn_pkg::BLK_K;
                            end else begin
                                o_bram_blk_sel <= attn_pkg::BLK_V;
                            end
                        end
                    end
                end
                attn_pkg::LD_WAIT_GAP: begin
                    state    <= attn_pkg::LD_REQ;
                    o_rd_ena <= 1'b1;                       // next block request
                end
                default: begin
                    state    <= attn_pkg::LD_IDLE;
                    o_rd_ena <= 1'b0;
                end
            endcase
        end
    end

    // block registers, written only on the matching valid pulse
    always_ff @(posedge I_CLK) begin
        if (blk_hit) begin
            case (o_bram_blk_sel)
                attn_pkg::BLK_Q: o_mat_q <= i_bram_rd_mat;
                attn_pkg::BLK_K: o_mat_k <= i_bram_rd_mat;
                default:         o_mat_v <= i_bram_rd_mat;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/attn_sa_sequencer.sv
`default_nettype none

`include "attn_settings.svh"

module attn_sa_sequencer (
    input  logic                I_CLK,
    input  logic                I_ASYN_RSTN,
    input  logic                i_attn_start,
    input  logic                i_ld_done,
    input  attn_pkg::data_t     i_mat_q     [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    input  attn_pkg::data_t     i_mat_k     [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    input  attn_pkg::data_t     i_mat_v     [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    input  logic                i_sa_vld,
    input  attn_pkg::data_t     i_sa_result [0:`ATTN_TILE-1][0:`ATTN_TILE-1],
    output logic                o_ld_go,
    output logic                o_sa_start,
    output attn_pkg::data_t     o_mat_1     [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output attn_pkg::data_t     o_mat_2     [0:`ATTN_DK-1][0:`ATTN_TILE-1],
    output attn_pkg::dim_t      o_m_dim,
    output logic                o_pv_capture,
    output attn_pkg::tile_idx_t o_pv_tile,
    output logic                o_run_clear,
    output logic                o_run_done
);

    attn_pkg::seq_state_e state;
    attn_pkg::tile_idx_t  tile_cnt;           // current v column tile
    logic                 run_idle;
    logic                 last_tile;

    attn_pkg::data_t k_trans  [0:`ATTN_DK-1][0:`ATTN_TILE-1];   // k^t
    attn_pkg::data_t res_op   [0:`ATTN_TILE-1][0:`ATTN_DK-1];   // sa result, cols 0..3
    attn_pkg::data_t scale_op [0:`ATTN_DK-1][0:`ATTN_TILE-1];   // diag in rows 0..3
    attn_pkg::data_t v_op     [0:`ATTN_DK-1][0:`ATTN_TILE-1];   // v tile in rows 0..3

    assign run_idle     = (state == attn_pkg::SEQ_IDLE) || (state == attn_pkg::SEQ_DONE);
    assign last_tile    = (tile_cnt == attn_pkg::tile_idx_t'(`ATTN_NTILE - 1));
    assign o_run_clear  = i_attn_start && run_idle;           // busy starts dropped
    assign o_pv_capture = (state == attn_pkg::SEQ_PV) && i_sa_vld;
    assign o_run_done   = o_pv_capture && last_tile;
    assign o_pv_tile    = tile_cnt;

    //////////////////////////////
    // operand shaping
    //////////////////////////////

    always_comb begin
        for (int r = 0; r < `ATTN_DK; r++) begin
            for (int c = 0; c < `ATTN_TILE; c++) begin
                k_trans[r][c] = i_mat_k[c][r];
            end
        end
    end

    // unused operand areas stay zero so the SA sums nothing extra
    always_comb begin
        res_op   = '{default: '0};
        scale_op = '{default: '0};
        v_op     = '{default: '0};
        for (int r = 0; r < `ATTN_TILE; r++) begin
            for (int c = 0; c < `ATTN_TILE; c++) begin
                res_op[r][c]   = i_sa_result[r][c];
                scale_op[r][c] = (r == c) ? attn_pkg::data_t'(`ATTN_SCALE) : '0;
                v_op[r][c]     = i_mat_v[r][int'(tile_cnt) * `ATTN_TILE + c];
            end
        end
    end

    //////////////////////////////
    // operation FSM
    //////////////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state      <= attn_pkg::SEQ_IDLE;
            tile_cnt   <= '0;
            o_ld_go    <= 1'b0;
            o_sa_start <= 1'b0;
            o_mat_1    <= '{default: '0};
            o_mat_2    <= '{default: '0};
            o_m_dim    <= '0;
        end else begin
            o_ld_go    <= 1'b0;
            o_sa_start <= 1'b0;
            case (state)
                attn_pkg::SEQ_IDLE, attn_pkg::SEQ_DONE: begin
                    if (i_attn_start) begin
                        state   <= attn_pkg::SEQ_LOAD;
                        o_ld_go <= 1'b1;
                    end
                end
                attn_pkg::SEQ_LOAD: begin
                    if (i_ld_done) begin
                        state <= attn_pkg::SEQ_CLR_QK;
                    end
                end
                attn_pkg::SEQ_CLR_QK: begin
                    state      <= attn_pkg::SEQ_QK;
                    o_mat_1    <= i_mat_q;
                    o_mat_2    <= k_trans;
                    o_m_dim    <= attn_pkg::dim_t'(`ATTN_DK);
                    o_sa_start <= 1'b1;
                end
                attn_pkg::SEQ_QK: begin
                    if (i_sa_vld) begin
                        state   <= attn_pkg::SEQ_CLR_SCALE;
                        o_mat_1 <= res_op;                  // s becomes first operand
                    end
                end
                attn_pkg::SEQ_CLR_SCALE: begin
                    state      <= attn_pkg::SEQ_SCALE;
                    o_mat_2    <= scale_op;
                    o_m_dim    <= attn_pkg::dim_t'(`ATTN_TILE);
                    o_sa_start <= 1'b1;
                end
                attn_pkg::SEQ_SCALE: begin
                    if (i_sa_vld) begin
                        state    <= attn_pkg::SEQ_CLR_PV;
                        o_mat_1  <= res_op;                 // p, kept for all v tiles
                        tile_cnt <= '0;
                    end
                end
                attn_pkg::SEQ_CLR_PV: begin
                    state      <= attn_pkg::SEQ_PV;
                    o_mat_2    <= v_op;
                    o_m_dim    <= attn_pkg::dim_t'(`ATTN_TILE);
                    o_sa_start <= 1'b1;
                end
                attn_pkg::SEQ_PV: begin
                    if (i_sa_vld) begin
                        if (last_tile) begin
                            state <= attn_pkg::SEQ_DONE;
                        end else begin
                            state    <= attn_pkg::SEQ_CLR_PV;
                            tile_cnt <= tile_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= attn_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/attn_out_collector.sv
`default_nettype none

`include "attn_settings.svh"

module attn_out_collector (
    input  logic                I_CLK,
    input  logic                I_ASYN_RSTN,
    input  logic                i_run_clear,
    input  logic                i_pv_capture,
    input  attn_pkg::tile_idx_t i_pv_tile,
    input  logic                i_run_done,
    input  attn_pkg::data_t     i_sa_result [0:`ATTN_TILE-1][0:`ATTN_TILE-1],
    output attn_pkg::data_t     o_att_data  [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output logic                o_data_vld
);

    //////////////////////////////
    // output matrix and valid
    //////////////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            o_att_data <= '{default: '0};
            o_data_vld <= 1'b0;
        end else if (i_run_clear) begin
            o_att_data <= '{default: '0};        // new run starts from zero
            o_data_vld <= 1'b0;
        end else begin
            if (i_pv_capture) begin
                // tile j lands in cols j*TILE .. j*TILE+TILE-1
                for (int r = 0; r < `ATTN_TILE; r++) begin
                    for (int c = 0; c < `ATTN_TILE; c++) begin
                        o_att_data[r][int'(i_pv_tile) * `ATTN_TILE + c] <= i_sa_result[r][c];
                    end
                end
            end
            if (i_run_done) begin
                o_data_vld <= 1'b1;                  // same edge as last tile write
            end
        end
    end

endmodule

`default_nettype wire

// File: design/attn_tile_top.sv
`default_nettype none

`include "attn_settings.svh"

module attn_tile_top (
    input  logic              I_CLK,
    input  logic              I_ASYN_RSTN,
    input  logic              i_attn_start,
    input  logic              i_bram_rd_vld,
    input  attn_pkg::data_t   i_bram_rd_mat [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    input  logic              i_sa_vld,
    input  attn_pkg::data_t   i_sa_result   [0:`ATTN_TILE-1][0:`ATTN_TILE-1],
    output logic              o_rd_ena,
    output attn_pkg::blk_id_e o_bram_blk_sel,
    output logic              o_sa_start,
    output attn_pkg::data_t   o_mat_1       [0:`ATTN_TILE-1][0:`ATTN_DK-1],
    output attn_pkg::data_t   o_mat_2       [0:`ATTN_DK-1][0:`ATTN_TILE-1],
    output attn_pkg::dim_t    o_m_dim,
    output logic              o_data_vld,
    output attn_pkg::data_t   o_att_data    [0:`ATTN_TILE-1][0:`ATTN_DK-1]
);

    logic                ld_go;
    logic                ld_done;
    attn_pkg::data_t     mat_q [0:`ATTN_TILE-1][0:`ATTN_DK-1];
    attn_pkg::data_t     mat_k [0:`ATTN_TILE-1][0:`ATTN_DK-1];
    attn_pkg::data_t     mat_v [0:`ATTN_TILE-1][0:`ATTN_DK-1];
    logic                pv_capture;           // p*v result this cycle
    attn_pkg::tile_idx_t pv_tile;
    logic                run_clear;
    logic                run_done;

    attn_tile_loader u_loader (
        .I_CLK          (I_CLK),
        .I_ASYN_RSTN    (I_ASYN_RSTN),
        .i_ld_go        (ld_go),
        .i_bram_rd_vld  (i_bram_rd_vld),
        .i_bram_rd_mat  (i_bram_rd_mat),
        .o_rd_ena       (o_rd_ena),
        .o_bram_blk_sel (o_bram_blk_sel),
        .o_ld_done      (ld_done),
        .o_mat_q        (mat_q),
        .o_mat_k        (mat_k),
        .o_mat_v        (mat_v)
    );

    attn_sa_sequencer u_seq (
        .I_CLK        (I_CLK),
        .I_ASYN_RSTN  (I_ASYN_RSTN),
        .i_attn_start (i_attn_start),
        .i_ld_done    (ld_done),
        .i_mat_q      (mat_q),
        .i_mat_k      (mat_k),
        .i_mat_v      (mat_v),
        .i_sa_vld     (i_sa_vld),
        .i_sa_result  (i_sa_result),
        .o_ld_go      (ld_go),
        .o_sa_start   (o_sa_start),
        .o_mat_1      (o_mat_1),
        .o_mat_2      (o_mat_2),
        .o_m_dim      (o_m_dim),
        .o_pv_capture (pv_capture),
        .o_pv_tile    (pv_tile),
        .o_run_clear  (run_clear),
        .o_run_done   (run_done)
    );

    attn_out_collector u_collect (
        .I_CLK        (I_CLK),
        .I_ASYN_RSTN  (I_ASYN_RSTN),
        .i_run_clear  (run_clear),
        .i_pv_capture (pv_capture),
        .i_pv_tile    (pv_tile),
        .i_run_done   (run_done),
        .i_sa_result  (i_sa_result),             // straight from the SA
        .o_att_data   (o_att_data),
        .o_data_vld   (o_data_vld)
    );

endmodule

`default_nettype wire

// File: verification/tb_attn_tile.sv
`default_nettype none

`include "attn_settings.svh"

module tb_attn_tile;

    localparam int T         = `ATTN_TILE;
    localparam int DK        = `ATTN_DK;
    localparam int N_OPS     = 2 + `ATTN_NTILE;   // qk, scale, one per v tile
    localparam int RUN_LIMIT = 500;               // cycles allowed per run

    logic              I_CLK = 1'b0;
    logic              I_ASYN_RSTN;
    logic              i_attn_start;
    logic              i_bram_rd_vld;
    attn_pkg::data_t   i_bram_rd_mat [0:T-1][0:DK-1];
    logic              i_sa_vld;
    attn_pkg::data_t   i_sa_result   [0:T-1][0:T-1];
    logic              o_rd_ena;
    attn_pkg::blk_id_e o_bram_blk_sel;
    logic              o_sa_start;
    attn_pkg::data_t   o_mat_1       [0:T-1][0:DK-1];
    attn_pkg::data_t   o_mat_2       [0:DK-1][0:T-1];
    attn_pkg::dim_t    o_m_dim;
    logic              o_data_vld;
    attn_pkg::data_t   o_att_data    [0:T-1][0:DK-1];

    attn_pkg::data_t   q_blk   [0:T-1][0:DK-1];
    attn_pkg::data_t   k_blk   [0:T-1][0:DK-1];
    attn_pkg::data_t   v_blk   [0:T-1][0:DK-1];
    attn_pkg::data_t   s_ref   [0:T-1][0:T-1];
    attn_pkg::data_t   p_ref   [0:T-1][0:T-1];
    attn_pkg::data_t   o_ref   [0:T-1][0:DK-1];
    attn_pkg::data_t   sa_hold [0:T-1][0:T-1];   // result the SA model will return
    int                val_errs;
    int                proto_errs;

    attn_tile_top i_attn_tile_top (
        .I_CLK          (I_CLK),
        .I_ASYN_RSTN    (I_ASYN_RSTN),
        .i_attn_start   (i_attn_start),
        .i_bram_rd_vld  (i_bram_rd_vld),
        .i_bram_rd_mat  (i_bram_rd_mat),
        .i_sa_vld       (i_sa_vld),
        .i_sa_result    (i_sa_result),
        .o_rd_ena       (o_rd_ena),
        .o_bram_blk_sel (o_bram_blk_sel),
        .o_sa_start     (o_sa_start),
        .o_mat_1        (o_mat_1),
        .o_mat_2        (o_mat_2),
        .o_m_dim        (o_m_dim),
        .o_data_vld     (o_data_vld),
        .o_att_data     (o_att_data)
    );

    always #5 I_CLK = ~I_CLK;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic compare_data(input string name, input attn_pkg::data_t got,
                                input attn_pkg::data_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_dim(input string name, input attn_pkg::dim_t got,
                               input attn_pkg::dim_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_blk(input string name, input attn_pkg::blk_id_e got,
                               input attn_pkg::blk_id_e exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_protocol_error(input string msg);
        proto_errs++;
        $display("ERROR: %s", msg);
    endtask

    //////////////////////////////
    // stimulus and reference
    //////////////////////////////

    task automatic randomize_blocks();
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < DK; c++) begin
                q_blk[r][c] = attn_pkg::data_t'($urandom);
                k_blk[r][c] = attn_pkg::data_t'($urandom);
                v_blk[r][c] = attn_pkg::data_t'($urandom);
            end
        end
    endtask

    // s = q*k^t, p = s*scale, o = p*v, each kept to 8 bits
    task automatic compute_reference();
        int acc;
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < T; c++) begin
                acc = 0;
                for (int i = 0; i < DK; i++) begin
                    acc += int'(q_blk[r][i]) * int'(k_blk[c][i]);
                end
                s_ref[r][c] = attn_pkg::data_t'(acc);
                p_ref[r][c] = attn_pkg::data_t'(int'(s_ref[r][c]) * `ATTN_SCALE);
            end
        end
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < DK; c++) begin
                acc = 0;
                for (int i = 0; i < T; i++) begin
                    acc += int'(p_ref[r][i]) * int'(v_blk[i][c]);
                end
                o_ref[r][c] = attn_pkg::data_t'(acc);
            end
        end
    endtask

    // what the external SA computes from the operands it sees
    task automatic compute_sa_product();
        int acc;
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < T; c++) begin
                acc = 0;
                for (int i = 0; i < DK; i++) begin
                    if (i < int'(o_m_dim)) begin
                        acc += int'(o_mat_1[r][i]) * int'(o_mat_2[i][c]);
                    end
                end
                sa_hold[r][c] = attn_pkg::data_t'(acc);
            end
        end
    endtask

    task automatic check_operands(input int op);
        attn_pkg::data_t exp_1 [0:T-1][0:DK-1];
        attn_pkg::data_t exp_2 [0:DK-1][0:T-1];
        attn_pkg::dim_t  exp_dim;
        exp_1 = '{default: '0};
        exp_2 = '{default: '0};
        exp_dim = attn_pkg::dim_t'(T);
        if (op == 0) begin
            exp_1 = q_blk;
            for (int r = 0; r < DK; r++) begin
                for (int c = 0; c < T; c++) begin
                    exp_2[r][c] = k_blk[c][r];               // k transposed
                end
            end
            exp_dim = attn_pkg::dim_t'(DK);
        end else begin
            for (int r = 0; r < T; r++) begin
                for (int c = 0; c < T; c++) begin
                    if (op == 1) begin
                        exp_1[r][c] = s_ref[r][c];
                        exp_2[r][c] = (r == c) ? attn_pkg::data_t'(`ATTN_SCALE) : '0;
                    end else begin
                        exp_1[r][c] = p_ref[r][c];
                        exp_2[r][c] = v_blk[r][(op - 2) * T + c];
                    end
                end
            end
        end
        compare_dim("o_m_dim", o_m_dim, exp_dim);
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < DK; c++) begin
                compare_data($sformatf("o_mat_1[%0d][%0d]", r, c), o_mat_1[r][c], exp_1[r][c]);
                compare_data($sformatf("o_mat_2[%0d][%0d]", c, r), o_mat_2[c][r], exp_2[c][r]);
            end
        end
    endtask

    task automatic check_output(input logic zero);
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < DK; c++) begin
                compare_data($sformatf("o_att_data[%0d][%0d]", r, c), o_att_data[r][c],
                             zero ? '0 : o_ref[r][c]);
            end
        end
    endtask

    //////////////////////////////
    // one run with bram and SA models
    //////////////////////////////

    task automatic run_attention(input bit busy_start);
        attn_pkg::blk_id_e blk_exp [0:2];
        int  cycle;
        int  n_blk;
        int  n_op;
        int  rd_wait;
        int  sa_wait;
        bit  rd_busy;
        bit  rd_answered;
        bit  sa_busy;
        bit  busy_sent;
        bit  done;
        blk_exp = '{attn_pkg::BLK_Q, attn_pkg::BLK_K, attn_pkg::BLK_V};
        cycle = 0;
        n_blk = 0;
        n_op = 0;
        rd_wait = 0;
        sa_wait = 0;
        rd_busy = 1'b0;
        rd_answered = 1'b0;
        sa_busy = 1'b0;
        busy_sent = 1'b0;
        done = 1'b0;
        randomize_blocks();
        compute_reference();
        i_attn_start = 1'b1;                             // called just after a negedge
        while (!done && cycle < RUN_LIMIT) begin
            @(negedge I_CLK);
            cycle++;
            i_attn_start  = 1'b0;
            if (busy_start && !busy_sent && n_op == N_OPS) begin
                i_attn_start = 1'b1;                     // last tile still in the SA
                busy_sent    = 1'b1;
            end
            i_bram_rd_vld = 1'b0;
            i_bram_rd_mat = '{default: '0};
            i_sa_vld      = 1'b0;
            i_sa_result   = '{default: '0};
            if (cycle == 1) begin
                compare_bit("o_data_vld", o_data_vld, 1'b0);
                check_output(1'b1);                      // cleared by the start
            end
            // block-RAM model
            if (rd_answered && o_rd_ena) begin
                report_protocol_error("o_rd_ena still high in the cycle after the valid pulse");
            end
            rd_answered = 1'b0;
            if (rd_busy) begin
                if (!o_rd_ena) begin
                    report_protocol_error("o_rd_ena dropped before the valid pulse");
                    rd_busy = 1'b0;
                end else begin
                    compare_blk("o_bram_blk_sel", o_bram_blk_sel, blk_exp[n_blk]);
                    rd_wait--;
                    if (rd_wait == 0) begin
                        i_bram_rd_vld = 1'b1;
                        case (o_bram_blk_sel)
                            attn_pkg::BLK_Q: i_bram_rd_mat = q_blk;
                            attn_pkg::BLK_K: i_bram_rd_mat = k_blk;
                            default:         i_bram_rd_mat = v_blk;
                        endcase
                        n_blk++;
                        rd_busy = 1'b0;
                        rd_answered = 1'b1;
                    end
                end
            end else if (o_rd_ena) begin
                if (n_blk >= 3) begin
                    report_protocol_error("read request after all three blocks were read");
                end else begin
                    compare_blk("o_bram_blk_sel", o_bram_blk_sel, blk_exp[n_blk]);
                    rd_busy = 1'b1;
                    rd_wait = 1 + int'($urandom % 5);
                end
            end
            // SA model
            if (sa_busy) begin
                if (o_sa_start) begin
                    report_protocol_error("o_sa_start pulsed while the SA was busy");
                end
                sa_wait--;
                if (sa_wait == 0) begin
                    i_sa_vld = 1'b1;
                    i_sa_result = sa_hold;
                    sa_busy = 1'b0;
                end
            end else if (o_sa_start) begin
                if (n_op < N_OPS) begin
                    check_operands(n_op);
                end else begin
                    report_protocol_error("more SA start pulses than operations");
                end
                compute_sa_product();
                n_op++;
                sa_busy = 1'b1;
                sa_wait = 2 + int'($urandom % 7);
            end
            if (o_data_vld) begin
                done = 1'b1;
            end
        end
        i_attn_start = 1'b0;
        if (!done) begin
            report_protocol_error("timed out waiting for o_data_vld");
        end else begin
            if (n_blk != 3) begin
                report_protocol_error($sformatf("%0d blocks read instead of 3", n_blk));
            end
            if (n_op != N_OPS) begin
                report_protocol_error($sformatf("%0d SA starts instead of %0d", n_op, N_OPS));
            end
            check_output(1'b0);
        end
    endtask

    task automatic hold_valid(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge I_CLK);
            compare_bit("o_data_vld", o_data_vld, 1'b1);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_state();
        compare_bit("o_rd_ena", o_rd_ena, 1'b0);
        compare_bit("o_sa_start", o_sa_start, 1'b0);
        compare_bit("o_data_vld", o_data_vld, 1'b0);
        compare_dim("o_m_dim", o_m_dim, '0);
        check_output(1'b1);
        for (int r = 0; r < T; r++) begin
            for (int c = 0; c < DK; c++) begin
                compare_data($sformatf("o_mat_1[%0d][%0d]", r, c), o_mat_1[r][c], '0);
                compare_data($sformatf("o_mat_2[%0d][%0d]", c, r), o_mat_2[c][r], '0);
            end
        end
    endtask

    task automatic test_basic_run();
        run_attention(1'b0);
        hold_valid(6);
    endtask

    task automatic test_restart();
        run_attention(1'b0);                             // new blocks, new latencies
        hold_valid(4);
    endtask

    task automatic test_busy_start();
        run_attention(1'b1);
        hold_valid(4);
    endtask

    initial begin
        void'($urandom(32'h7703));
        I_ASYN_RSTN   = 1'b0;
        i_attn_start  = 1'b0;
        i_bram_rd_vld = 1'b0;
        i_bram_rd_mat = '{default: '0};
        i_sa_vld      = 1'b0;
        i_sa_result   = '{default: '0};
        val_errs      = 0;
        proto_errs    = 0;
        repeat (2) @(posedge I_CLK);
        @(negedge I_CLK);
        I_ASYN_RSTN = 1'b1;
        @(negedge I_CLK);
        test_reset_state();
        test_basic_run();
        test_restart();
        test_busy_start();
        $display("error counts: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/attn_pkg.sv
design/attn_tile_loader.sv
design/attn_sa_sequencer.sv
design/attn_out_collector.sv
design/attn_tile_top.sv
verification/tb_attn_tile.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_attn_tile -o tb_attn_tile
./obj_dir/tb_attn_tile | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
